// File: include/xadc_acq_params.svh
`ifndef XADC_ACQ_PARAMS_SVH
`define XADC_ACQ_PARAMS_SVH

// ADC result and FIFO word layout
`define XADC_SAMPLE_W   12
`define XADC_WORD_W     64
`define XADC_LANES      5       // Results packed per FIFO word

// Frame limits
`define XADC_MAX_WORDS  150     // Frame forced closed here
`define XADC_LEN_W      12      // Width of packet_len

// Request fields
`define XADC_CNT_W      11      // Samples per chip
`define XADC_DELAY_W    18      // Inter-sample delay in clocks

// Front-end chips on the board
`define XADC_VMM_COUNT  8

`endif

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_xadc_acq -f vlog.f -o tb_xadc_acq \
    && ./obj_dir/tb_xadc_acq > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

// File: src/acq_config.sv
`timescale 1ns/100ps
`include "xadc_acq_params.svh"

module acq_config
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        data_in_rdy,
    input  logic [15:0]                 vmm_id,
    input  logic [`XADC_CNT_W-1:0]      sample_size,
    input  logic [`XADC_DELAY_W-1:0]    delay_in,
    input  logic                        xadc_busy,
    output logic                        start,
    output logic                        all_vmm,
    output xadc_acq_pkg::vmm_sel_t      first_vmm,
    output logic [`XADC_CNT_W-1:0]      sample_size_q,
    output logic [`XADC_DELAY_W-1:0]    delay_q
);

    logic rdy_q;
    logic req_edge;

    // New request only when the sequencer is free
    assign req_edge = data_in_rdy & ~rdy_q & ~xadc_busy;

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            rdy_q <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            rdy_q <= data_in_rdy;
            start <= req_edge;      // One cycle after the edge
        end
    end

    // Settings captured on the edge and held while busy
    always_ff @(posedge clk125)
    begin
        if (req_edge)
        begin
            sample_size_q <= sample_size;
            delay_q       <= delay_in;
            if (vmm_id[3:0] > 4'd7)
            begin
                all_vmm   <= 1'b1;  // Sweep every chip from 0
                first_vmm <= '0;
            end
            else
            begin
                all_vmm   <= 1'b0;
                first_vmm <= vmm_id[2:0];
            end
        end
    end

endmodule

// File: src/adc_channel_ctrl.sv
`timescale 1ns/100ps

module adc_channel_ctrl
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        sample_req,
    input  xadc_acq_pkg::vmm_sel_t      vmm_sel,
    input  logic                        adc_eoc,
    input  logic [15:0]                 adc_data,
    output logic                        adc_convst,
    output logic [4:0]                  adc_channel,
    output logic                        sample_valid,
    output xadc_acq_pkg::sample_t       sample
);

    xadc_acq_pkg::chan_state_t state;

    assign sample_valid = (state == xadc_acq_pkg::chan_store);

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state       <= xadc_acq_pkg::chan_idle;
            adc_convst  <= 1'b0;
            adc_channel <= '0;
        end
        else
        begin
            adc_convst <= 1'b0;
            case (state)
                xadc_acq_pkg::chan_idle:
                begin
                    if (sample_req)
                    begin
                        adc_channel <= 5'(vmm_sel);     // PDO input of that chip
                        adc_convst  <= 1'b1;
                        state       <= xadc_acq_pkg::chan_convert;
                    end
                end

                xadc_acq_pkg::chan_convert:
                    state <= xadc_acq_pkg::chan_wait_eoc;

                // Latency set by the converter
                xadc_acq_pkg::chan_wait_eoc:
                begin
                    if (adc_eoc)
                        state <= xadc_acq_pkg::chan_store;
                end

                xadc_acq_pkg::chan_store:
                    state <= xadc_acq_pkg::chan_idle;

                default:
                    state <= xadc_acq_pkg::chan_idle;
            endcase
        end
    end

    // Result is left aligned in the 16-bit data word
    always_ff @(posedge clk125)
    begin
        if (state == xadc_acq_pkg::chan_wait_eoc && adc_eoc)
            sample <= adc_data[15:4];
    end

endmodule

// File: src/fifo_writer.sv
`timescale 1ns/100ps
`include "xadc_acq_params.svh"

module fifo_writer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        word_full,
    input  logic [`XADC_WORD_W-1:0]     word,
    input  logic [2:0]                  lanes_used,
    input  logic                        flush,
    output logic                        word_clear,
    output logic                        flush_done,
    output logic [`XADC_WORD_W-1:0]     fifo_bus,
    output logic                        data_fifo_enable,
    output logic [`XADC_LEN_W-1:0]      packet_len,
    output logic                        end_of_data
);

    xadc_acq_pkg::wr_state_t    state;
    logic [`XADC_LEN_W-1:0]     word_cnt;
    logic [`XADC_LEN_W-1:0]     word_cnt_nxt;
    logic                       flush_pend;     // Flush seen during a write
    logic                       serve_flush;

    assign word_cnt_nxt     = word_cnt + 1'b1;
    assign data_fifo_enable = (state == xadc_acq_pkg::wr_write);
    assign word_clear       = (state == xadc_acq_pkg::wr_write);
    assign end_of_data      = (state == xadc_acq_pkg::wr_close);
    assign flush_done       = (state == xadc_acq_pkg::wr_gap) && serve_flush;

    //////////////////////////////////////////////////////////////////////
    // Word writes and frame close
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state       <= xadc_acq_pkg::wr_idle;
            word_cnt    <= '0;
            packet_len  <= '0;
            flush_pend  <= 1'b0;
            serve_flush <= 1'b0;
        end
        else
        begin
            if (flush)
                flush_pend <= 1'b1;
            case (state)
                xadc_acq_pkg::wr_idle:
                begin
                    if (word_full)
                        state <= xadc_acq_pkg::wr_write;
                    else if (flush || flush_pend)
                    begin
                        flush_pend  <= 1'b0;
                        serve_flush <= 1'b1;
                        if (lanes_used != '0)
                            state <= xadc_acq_pkg::wr_write;   // Partial word
                        else if (word_cnt != '0)
                        begin
                            packet_len <= word_cnt;
                            word_cnt   <= '0;
                            state      <= xadc_acq_pkg::wr_close;
                        end
                        else
                            state <= xadc_acq_pkg::wr_gap;     // Nothing left to send
                    end
                end

                xadc_acq_pkg::wr_write:
                begin
                    if (word_cnt_nxt == `XADC_MAX_WORDS || serve_flush)
                    begin
                        packet_len <= word_cnt_nxt;
                        word_cnt   <= '0;
                        state      <= xadc_acq_pkg::wr_close;
                    end
                    else
                    begin
                        word_cnt <= word_cnt_nxt;
                        state    <= xadc_acq_pkg::wr_gap;
                    end
                end

                xadc_acq_pkg::wr_close:
                    state <= xadc_acq_pkg::wr_gap;

                xadc_acq_pkg::wr_gap:
                begin
                    serve_flush <= 1'b0;
                    state       <= xadc_acq_pkg::wr_idle;
                end

                default:
                    state <= xadc_acq_pkg::wr_idle;
            endcase
        end
    end

    // Word is stable while idle and held through the write cycle
    always_ff @(posedge clk125)
    begin
        if (state == xadc_acq_pkg::wr_idle)
            fifo_bus <= word;
    end

endmodule

// File: src/packet_packer.sv
`timescale 1ns/100ps
`include "xadc_acq_params.svh"

module packet_packer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        sample_valid,
    input  xadc_acq_pkg::sample_t       sample,
    input  xadc_acq_pkg::vmm_sel_t      vmm_sel,
    input  logic                        word_clear,
    output logic [`XADC_WORD_W-1:0]     word,
    output logic                        word_full,
    output logic [2:0]                  lanes_used
);

    localparam int hdr_w = $bits(xadc_acq_pkg::vmm_sel_t);

    // Word layout
    //   [63]     always zero
    //   [62:60]  chip index
    //   [59:0]   five results, lane 0 in the low bits
    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            word       <= '0;
            lanes_used <= '0;
            word_full  <= 1'b0;
        end
        else
        begin
            word_full <= 1'b0;
            if (word_clear)
            begin
                word       <= '0;   // Unused lanes read as zero
                lanes_used <= '0;
            end
            else if (sample_valid)
            begin
                word[int'(lanes_used) * `XADC_SAMPLE_W +: `XADC_SAMPLE_W] <= sample;
                word[`XADC_WORD_W-2 -: hdr_w] <= vmm_sel;
                lanes_used <= lanes_used + 1'b1;
                if (lanes_used == 3'(`XADC_LANES - 1))
                    word_full <= 1'b1;      // Last lane written
            end
        end
    end

endmodule

// File: src/sample_sequencer.sv
`timescale 1ns/100ps
`include "xadc_acq_params.svh"

module sample_sequencer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        all_vmm,
    input  xadc_acq_pkg::vmm_sel_t      first_vmm,
    input  logic [`XADC_CNT_W-1:0]      sample_size_q,
    input  logic [`XADC_DELAY_W-1:0]    delay_q,
    input  logic                        sample_valid,
    input  logic                        flush_done,
    input  logic                        data_in_rdy,
    input  logic                        udp_done,
    output logic                        sample_req,
    output xadc_acq_pkg::vmm_sel_t      vmm_sel,
    output logic                        flush,
    output logic                        xadc_busy
);

    localparam xadc_acq_pkg::vmm_sel_t last_vmm =
        xadc_acq_pkg::vmm_sel_t'(`XADC_VMM_COUNT - 1);

    xadc_acq_pkg::seq_state_t   state;
    logic [`XADC_CNT_W-1:0]     sample_cnt;
    logic [`XADC_DELAY_W-1:0]   delay_cnt;

    assign sample_req = (state == xadc_acq_pkg::seq_request);

    //////////////////////////////////////////////////////////////////////
    // Acquisition sequence per request
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state      <= xadc_acq_pkg::seq_idle;
            sample_cnt <= '0;
            delay_cnt  <= '0;
            vmm_sel    <= '0;
            flush      <= 1'b0;
            xadc_busy  <= 1'b0;
        end
        else
        begin
            flush <= (state == xadc_acq_pkg::seq_flush);   // Lets the packer settle
            case (state)
                xadc_acq_pkg::seq_idle:
                begin
                    if (start)
                    begin
                        xadc_busy  <= 1'b1;
                        vmm_sel    <= first_vmm;
                        sample_cnt <= '0;
                        state      <= xadc_acq_pkg::seq_request;
                    end
                end

                xadc_acq_pkg::seq_request:
                begin
                    sample_cnt <= sample_cnt + 1'b1;
                    state      <= xadc_acq_pkg::seq_wait_sample;
                end

                xadc_acq_pkg::seq_wait_sample:
                begin
                    if (sample_valid)
                    begin
                        delay_cnt <= '0;
                        if (sample_cnt >= sample_size_q)
                            state <= xadc_acq_pkg::seq_flush;  // Chip done
                        else
                            state <= xadc_acq_pkg::seq_delay;
                    end
                end

                xadc_acq_pkg::seq_delay:
                begin
                    if (delay_cnt == delay_q)
                        state <= xadc_acq_pkg::seq_request;
                    else
                        delay_cnt <= delay_cnt + 1'b1;
                end

                xadc_acq_pkg::seq_flush:
                    state <= xadc_acq_pkg::seq_wait_flush;

                xadc_acq_pkg::seq_wait_flush:
                begin
                    if (flush_done)
                    begin
                        if (all_vmm && vmm_sel != last_vmm)
                        begin
                            vmm_sel    <= vmm_sel + 1'b1;  // Next chip
                            sample_cnt <= '0;
                            state      <= xadc_acq_pkg::seq_request;
                        end
                        else
                            state <= xadc_acq_pkg::seq_release;
                    end
                end

                // Old request gone and UDP frame sent
                xadc_acq_pkg::seq_release:
                begin
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state     <= xadc_acq_pkg::seq_idle;
                    end
                end

                default:
                    state <= xadc_acq_pkg::seq_idle;
            endcase
        end
    end

endmodule

// File: src/xadc_acq_pkg.sv
`include "xadc_acq_params.svh"

package xadc_acq_pkg;

    // One ADC conversion result
    typedef logic [`XADC_SAMPLE_W-1:0] sample_t;

    // Front-end chip index
    typedef logic [$clog2(`XADC_VMM_COUNT)-1:0] vmm_sel_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_request,
        seq_wait_sample,
        seq_delay,
        seq_flush,
        seq_wait_flush,
        seq_release
    } seq_state_t;

    typedef enum logic [1:0] {
        chan_idle,
        chan_convert,
        chan_wait_eoc,
        chan_store
    } chan_state_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_write,
        wr_close,
        wr_gap
    } wr_state_t;

endpackage

// File: src/xadc_acq_top.sv
`timescale 1ns/100ps
`include "xadc_acq_params.svh"

module xadc_acq_top
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        data_in_rdy,
    input  logic [15:0]                 vmm_id,
    input  logic [`XADC_CNT_W-1:0]      sample_size,
    input  logic [`XADC_DELAY_W-1:0]    delay_in,
    input  logic                        udp_done,
    input  logic                        adc_eoc,
    input  logic [15:0]                 adc_data,
    output logic                        adc_convst,
    output logic [4:0]                  adc_channel,
    output logic [`XADC_WORD_W-1:0]     fifo_bus,
    output logic                        data_fifo_enable,
    output logic [`XADC_LEN_W-1:0]      packet_len,
    output logic                        end_of_data,
    output logic                        xadc_busy
);

    // Latched request
    logic                           start;
    logic                           all_vmm;
    xadc_acq_pkg::vmm_sel_t         first_vmm;
    logic [`XADC_CNT_W-1:0]         sample_size_q;
    logic [`XADC_DELAY_W-1:0]       delay_q;

    // Sequencer and conversion
    logic                           sample_req;
    xadc_acq_pkg::vmm_sel_t         vmm_sel;
    logic                           flush;
    logic                           flush_done;
    logic                           sample_valid;
    xadc_acq_pkg::sample_t          sample;

    // Packer to writer
    logic [`XADC_WORD_W-1:0]        word;
    logic                           word_full;
    logic                           word_clear;
    logic [2:0]                     lanes_used;

    //////////////////////////////////////////////////////////////////////
    // Request and sequencing
    //////////////////////////////////////////////////////////////////////
    acq_config i_acq_config
    (
        .clk125        (clk125),
        .rst           (rst),
        .data_in_rdy   (data_in_rdy),
        .vmm_id        (vmm_id),
        .sample_size   (sample_size),
        .delay_in      (delay_in),
        .xadc_busy     (xadc_busy),
        .start         (start),
        .all_vmm       (all_vmm),
        .first_vmm     (first_vmm),
        .sample_size_q (sample_size_q),
        .delay_q       (delay_q)
    );

    sample_sequencer i_sample_sequencer
    (
        .clk125        (clk125),
        .rst           (rst),
        .start         (start),
        .all_vmm       (all_vmm),
        .first_vmm     (first_vmm),
        .sample_size_q (sample_size_q),
        .delay_q       (delay_q),
        .sample_valid  (sample_valid),
        .flush_done    (flush_done),
        .data_in_rdy   (data_in_rdy),
        .udp_done      (udp_done),
        .sample_req    (sample_req),
        .vmm_sel       (vmm_sel),
        .flush         (flush),
        .xadc_busy     (xadc_busy)
    );

    //////////////////////////////////////////////////////////////////////
    // Conversion, packing and readout
    //////////////////////////////////////////////////////////////////////
    adc_channel_ctrl i_adc_channel_ctrl
    (
        .clk125        (clk125),
        .rst           (rst),
        .sample_req    (sample_req),
        .vmm_sel       (vmm_sel),
        .adc_eoc       (adc_eoc),
        .adc_data      (adc_data),
        .adc_convst    (adc_convst),
        .adc_channel   (adc_channel),
        .sample_valid  (sample_valid),
        .sample        (sample)
    );

    packet_packer i_packet_packer
    (
        .clk125        (clk125),
        .rst           (rst),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .vmm_sel       (vmm_sel),
        .word_clear    (word_clear),
        .word          (word),
        .word_full     (word_full),
        .lanes_used    (lanes_used)
    );

    fifo_writer i_fifo_writer
    (
        .clk125           (clk125),
        .rst              (rst),
        .word_full        (word_full),
        .word             (word),
        .lanes_used       (lanes_used),
        .flush            (flush),
        .word_clear       (word_clear),
        .flush_done       (flush_done),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data)
    );

endmodule

// File: test/tb_xadc_acq.sv
`timescale 1ns/100ps
`include "xadc_acq_params.svh"

module tb_xadc_acq;

    // One request and what it must produce
    typedef struct packed
    {
        logic [15:0]    vmm_id;
        logic [10:0]    sample_size;
        logic [17:0]    delay_in;
        logic [2:0]     first_chip;
        logic [3:0]     chips;
        logic [11:0]    words;      // FIFO words over the whole request
        logic [3:0]     frames;     // end_of_data pulses over the whole request
    } row_t;

    localparam int num_rows = 6;

    logic           clk125;
    logic           rst;
    logic           data_in_rdy;
    logic [15:0]    vmm_id;
    logic [10:0]    sample_size;
    logic [17:0]    delay_in;
    logic           udp_done;
    logic           adc_eoc;
    logic [15:0]    adc_data;
    logic           adc_convst;
    logic [4:0]     adc_channel;
    logic [63:0]    fifo_bus;
    logic           data_fifo_enable;
    logic [11:0]    packet_len;
    logic           end_of_data;
    logic           xadc_busy;

    row_t           rows [num_rows];
    logic [31:0]    lcg_state;
    logic [16:0]    exp_q [$];      // {adc_channel, result} per conversion
    int             conv_count;

    // Frame tracking of the current request
    logic [2:0]     cur_chip;
    int             cur_ss;
    int             cur_delay;
    int             chip_left;
    int             frame_words;
    int             words_seen;
    int             frames_seen;
    logic           close_pending;
    int             close_len;

    xadc_acq_top i_dut
    (
        .clk125           (clk125),
        .rst              (rst),
        .data_in_rdy      (data_in_rdy),
        .vmm_id           (vmm_id),
        .sample_size      (sample_size),
        .delay_in         (delay_in),
        .udp_done         (udp_done),
        .adc_eoc          (adc_eoc),
        .adc_data         (adc_data),
        .adc_convst       (adc_convst),
        .adc_channel      (adc_channel),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .xadc_busy        (xadc_busy)
    );

    initial
    begin
        clk125 = 1'b0;
        forever #20 clk125 = ~clk125;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // ADC model, one conversion at a time
    //////////////////////////////////////////////////////////////////////
    initial
    begin : adc_model
        logic [31:0]    r;
        int             latency;
        logic [11:0]    value;
        int             gap;        // Cycles since the last adc_eoc
        gap = 0;
        forever
        begin
            @(negedge clk125);
            gap++;
            if (adc_convst === 1'b1)
            begin
                // Next start inside a chip comes delay_in + 4 cycles after adc_eoc
                if (conv_count % cur_ss != 0)
                    check_value("conversion spacing", 64'(gap), 64'(cur_delay + 4));
                r       = lcg_next();
                latency = 2 + int'(r[30:28]);   // 2 to 9 cycles
                r       = lcg_next();
                value   = r[27:16];
                exp_q.push_back({adc_channel, value});
                conv_count++;
                repeat (latency) @(posedge clk125);
                adc_eoc  <= 1'b1;
                adc_data <= {value, r[3:0]};    // Low nibble is noise
                @(posedge clk125);
                adc_eoc  <= 1'b0;
                gap = 0;
            end
        end
    end

    // Expected word built from the queued conversions
    task automatic check_word();
        logic [63:0]    expected;
        logic [16:0]    entry;
        int             lanes;
        int             i;
        if (close_pending)
        begin
            $display("A FIFO word was written before the previous frame was closed");
            stop_on_failure();
        end
        lanes = (chip_left > `XADC_LANES) ? `XADC_LANES : chip_left;
        expected = '0;
        expected[62:60] = cur_chip;
        for (i = 0; i < lanes; i++)
        begin
            if (exp_q.size() == 0)
            begin
                $display("A FIFO word was written before its samples were converted");
                stop_on_failure();
            end
            entry = exp_q.pop_front();
            check_value("adc_channel", 64'(entry[16:12]), 64'(cur_chip));
            expected[i*12 +: 12] = entry[11:0];
        end
        check_value("fifo_bus", fifo_bus, expected);
        chip_left   = chip_left - lanes;
        frame_words = frame_words + 1;
        words_seen  = words_seen + 1;
        if (frame_words == `XADC_MAX_WORDS || chip_left == 0)
        begin
            close_pending = 1'b1;
            close_len     = frame_words;
            frame_words   = 0;
        end
        if (chip_left == 0)
        begin
            chip_left = cur_ss;
            cur_chip  = cur_chip + 1'b1;   // All-chip sweep goes upward
        end
    endtask

    task automatic check_close();
        if (!close_pending)
        begin
            $display("end_of_data pulsed with no frame to close");
            stop_on_failure();
        end
        check_value("packet_len", 64'(packet_len), 64'(close_len));
        close_pending = 1'b0;
        frames_seen   = frames_seen + 1;
    endtask

    initial
    begin : fifo_monitor
        forever
        begin
            @(negedge clk125);
            if (rst === 1'b0 && data_fifo_enable === 1'b1)
                check_word();
            if (rst === 1'b0 && end_of_data === 1'b1)
                check_close();
        end
    end

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (xadc_busy !== level && n < limit)
        begin
            @(negedge clk125);
            n++;
        end
        if (xadc_busy !== level)
        begin
            $display("Timeout: xadc_busy did not go to %0d in %0d cycles", level, limit);
            stop_on_failure();
        end
    endtask

    task automatic wait_run_done(input int words, input int frames, input int limit);
        int n;
        n = 0;
        while ((words_seen < words || frames_seen < frames || close_pending) && n < limit)
        begin
            @(negedge clk125);
            n++;
        end
        if (words_seen < words || frames_seen < frames || close_pending)
        begin
            $display("Timeout: the request did not deliver all its words and frames");
            stop_on_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One request from rising data_in_rdy to udp_done
    //////////////////////////////////////////////////////////////////////
    task automatic run_request(input row_t row);
        cur_chip      = row.first_chip;
        cur_ss        = row.sample_size;
        cur_delay     = row.delay_in;
        chip_left     = row.sample_size;
        frame_words   = 0;
        words_seen    = 0;
        frames_seen   = 0;
        close_pending = 1'b0;
        conv_count    = 0;
        @(negedge clk125);
        check_value("xadc_busy", 64'(xadc_busy), 64'd0);
        @(posedge clk125);
        vmm_id      <= row.vmm_id;
        sample_size <= row.sample_size;
        delay_in    <= row.delay_in;
        data_in_rdy <= 1'b1;
        wait_busy(1'b1, 10);

        // New edge with other settings while busy must be ignored
        repeat (20) @(posedge clk125);
        data_in_rdy <= 1'b0;
        @(posedge clk125);
        vmm_id      <= row.vmm_id ^ 16'h0001;
        sample_size <= row.sample_size + 11'd9;
        delay_in    <= 18'd0;
        data_in_rdy <= 1'b1;

        wait_run_done(row.words, row.frames, 60000);

        // Sender done alone does not release the request
        @(posedge clk125);
        udp_done <= 1'b1;
        repeat (5) @(negedge clk125);
        check_value("xadc_busy", 64'(xadc_busy), 64'd1);
        @(posedge clk125);
        udp_done    <= 1'b0;
        data_in_rdy <= 1'b0;
        repeat (5) @(negedge clk125);
        check_value("xadc_busy", 64'(xadc_busy), 64'd1);    // udp_done still low
        @(posedge clk125);
        udp_done <= 1'b1;
        wait_busy(1'b0, 10);
        @(posedge clk125);
        udp_done <= 1'b0;
        repeat (10) @(negedge clk125);
        check_value("conversion count", 64'(conv_count), 64'(row.chips * row.sample_size));
        check_value("words per request", 64'(words_seen), 64'(row.words));
        check_value("frames per request", 64'(frames_seen), 64'(row.frames));
        check_value("unread conversions", 64'(exp_q.size()), 64'd0);
    endtask

    initial
    begin
        // vmm_id, sample_size, delay_in, first chip, chips, words, frames
        rows[0] = '{16'h0003, 11'd7,   18'd3, 3'd3, 4'd1, 12'd2,   4'd1};
        rows[1] = '{16'h0008, 11'd12,  18'd0, 3'd0, 4'd8, 12'd24,  4'd8};
        rows[2] = '{16'h0005, 11'd760, 18'd1, 3'd5, 4'd1, 12'd152, 4'd2};
        rows[3] = '{16'h0006, 11'd10,  18'd5, 3'd6, 4'd1, 12'd2,   4'd1};
        rows[4] = '{16'h00ff, 11'd3,   18'd2, 3'd0, 4'd8, 12'd8,   4'd8};
        rows[5] = '{16'h0012, 11'd1,   18'd0, 3'd2, 4'd1, 12'd1,   4'd1};
        lcg_state  = 32'd48927;
        conv_count = 0;

        rst         <= 1'b1;
        data_in_rdy <= 1'b0;
        vmm_id      <= '0;
        sample_size <= '0;
        delay_in    <= '0;
        udp_done    <= 1'b0;
        adc_eoc     <= 1'b0;
        adc_data    <= '0;
        repeat (4) @(posedge clk125);
        rst <= 1'b0;

        @(negedge clk125);
        check_value("xadc_busy", 64'(xadc_busy), 64'd0);
        check_value("data_fifo_enable", 64'(data_fifo_enable), 64'd0);
        check_value("end_of_data", 64'(end_of_data), 64'd0);
        check_value("adc_convst", 64'(adc_convst), 64'd0);

        for (int r = 0; r < num_rows; r++)
            run_request(rows[r]);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
src/xadc_acq_pkg.sv
src/acq_config.sv
src/sample_sequencer.sv
src/adc_channel_ctrl.sv
src/packet_packer.sv
src/fifo_writer.sv
src/xadc_acq_top.sv
test/tb_xadc_acq.sv
